/* rename_pkg.sv */
`default_nettype none

package rename_pkg;

    // Architectural register file
    localparam int areg_w    = 5;
    localparam int arch_regs = 32;

    // Physical register file
    localparam int preg_w    = 6;
    localparam int phys_regs = 64;

    // Free list holds every register not mapped at reset
    localparam int freelist_size  = phys_regs - arch_regs;
    localparam int freelist_ptr_w = 5;   // Index bits, pointers add a wrap bit

    // Reorder buffer
    localparam int rob_depth = 16;
    localparam int rob_ptr_w = 4;        // Index bits, pointers add a wrap bit

    // One ROB entry packs {rd, new preg, old preg}
    localparam int rob_entry_w = areg_w + 2 * preg_w;

    // ROB recovery state, seen by the free list and the map table too
    typedef enum logic {
        rob_idle,
        rob_walk
    } rob_state_e;

endpackage

`default_nettype wire

/* free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module free_list import rename_pkg::*; (
    input  wire                clock,
    input  wire                reset_n,

    // Allocation from rename
    input  wire                alloc0,
    input  wire                alloc1,
    output logic [preg_w-1:0]  alloc_preg0,  // Head of queue
    output logic [preg_w-1:0]  alloc_preg1,  // Slot after head

    // Release from retirement
    input  wire                free0_valid,
    input  wire                free1_valid,
    input  wire [preg_w-1:0]   free0_preg,
    input  wire [preg_w-1:0]   free1_preg,

    // Walk rewind
    input  var rob_state_e     rob_state,
    input  wire                walk0_valid,
    input  wire                walk1_valid,

    output logic               can_alloc2    // Two or more free registers
);

    logic [preg_w-1:0]         slot_q [freelist_size];  // Free register numbers

    logic [freelist_ptr_w:0]   deq_q;     // Next register to hand out
    logic [freelist_ptr_w:0]   enq_q;     // Next slot for a released register
    logic [freelist_ptr_w:0]   free_cnt;

    logic [freelist_ptr_w-1:0] deq_idx0;
    logic [freelist_ptr_w-1:0] deq_idx1;
    logic [freelist_ptr_w-1:0] enq_idx0;
    logic [freelist_ptr_w-1:0] enq_idx1;

    logic [1:0]                alloc_cnt;
    logic [1:0]                rel_cnt;
    logic [1:0]                walk_cnt;

    // Slot indexes wrap naturally in the narrower width
    assign deq_idx0 = deq_q[freelist_ptr_w-1:0];
    assign deq_idx1 = deq_idx0 + 1'b1;
    assign enq_idx0 = enq_q[freelist_ptr_w-1:0];
    assign enq_idx1 = enq_idx0 + 1'b1;

    // Per-side counts, slot 1 only ever valid with slot 0
    assign alloc_cnt = {1'b0, alloc0} + {1'b0, alloc1};
    assign rel_cnt   = {1'b0, free0_valid} + {1'b0, free1_valid};
    assign walk_cnt  = {1'b0, walk0_valid} + {1'b0, walk1_valid};

    // Wrap bit makes the difference exact from 0 to freelist_size
    assign free_cnt   = enq_q - deq_q;
    assign can_alloc2 = free_cnt >= 2;

    // Presented registers, taken by rename only when alloc is raised
    assign alloc_preg0 = slot_q[deq_idx0];
    assign alloc_preg1 = slot_q[deq_idx1];

    // Pointer update
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            deq_q <= '0;
            enq_q <= {1'b1, {freelist_ptr_w{1'b0}}};  // Full at reset
        end else begin
            enq_q <= enq_q + rel_cnt;  // Retirement may land on any cycle
            if (rob_state == rob_walk) begin
                // Walked registers still sit behind deq, step back over them
                deq_q <= deq_q - walk_cnt;
            end else begin
                deq_q <= deq_q + alloc_cnt;
            end
        end
    end

    // Queue storage, 32..63 in order after reset
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < freelist_size; i++) begin
                slot_q[i] <= preg_w'(arch_regs + i);
            end
        end else begin
            if (free0_valid) begin
                slot_q[enq_idx0] <= free0_preg;
            end
            if (free1_valid) begin
                slot_q[enq_idx1] <= free1_preg;  // Right behind release 0
            end
        end
    end

endmodule

`default_nettype wire

/* rename_map_table.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_map_table import rename_pkg::*; (
    input  wire                clock,
    input  wire                reset_n,

    // Rename slots
    input  wire                wr0,
    input  wire                wr1,
    input  wire [areg_w-1:0]   rd0,
    input  wire [areg_w-1:0]   rd1,
    input  wire [areg_w-1:0]   rs0,
    input  wire [areg_w-1:0]   rs1,
    input  wire [preg_w-1:0]   prd0,
    input  wire [preg_w-1:0]   prd1,

    // Lookups
    output logic [preg_w-1:0]  map_prs0,
    output logic [preg_w-1:0]  map_prs1,
    output logic [preg_w-1:0]  map_old0,
    output logic [preg_w-1:0]  map_old1,

    // Walk restore, walk1 is the older entry
    input  var rob_state_e     rob_state,
    input  wire                walk0_valid,
    input  wire                walk1_valid,
    input  wire [areg_w-1:0]   walk0_rd,
    input  wire [areg_w-1:0]   walk1_rd,
    input  wire [preg_w-1:0]   walk0_old,
    input  wire [preg_w-1:0]   walk1_old
);

    logic [preg_w-1:0] map_q [arch_regs];  // Speculative arch to phys map

    logic              src1_hit;  // Slot 1 source is slot 0 destination
    logic              dst1_hit;  // Both slots write the same register

    assign src1_hit = wr0 && (rs1 == rd0);
    assign dst1_hit = wr0 && (rd1 == rd0);

    // Slot 0 reads the table as it stands
    assign map_prs0 = map_q[rs0];
    assign map_old0 = map_q[rd0];

    // Slot 1 sees slot 0's new mapping within the group
    assign map_prs1 = src1_hit ? prd0 : map_q[rs1];
    assign map_old1 = dst1_hit ? prd0 : map_q[rd1];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < arch_regs; i++) begin
                map_q[i] <= preg_w'(i);  // Identity map
            end
        end else if (rob_state == rob_walk) begin
            // Younger first so the older restore lands last
            if (walk0_valid) begin
                map_q[walk0_rd] <= walk0_old;
            end
            if (walk1_valid) begin
                map_q[walk1_rd] <= walk1_old;
            end
        end else begin
            if (wr0) begin
                map_q[rd0] <= prd0;
            end
            if (wr1) begin
                map_q[rd1] <= prd1;  // Slot 1 wins on equal rd
            end
        end
    end

endmodule

`default_nettype wire

/* rename_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_stage import rename_pkg::*; (
    input  wire                clock,
    input  wire                reset_n,

    // Incoming group
    input  wire                in0_valid,
    input  wire [areg_w-1:0]   in0_rd,
    input  wire [areg_w-1:0]   in0_rs,
    input  wire                in1_valid,
    input  wire [areg_w-1:0]   in1_rd,
    input  wire [areg_w-1:0]   in1_rs,
    output logic               in_ready,

    // Free list
    output logic               alloc0,
    output logic               alloc1,
    input  wire [preg_w-1:0]   alloc_preg0,
    input  wire [preg_w-1:0]   alloc_preg1,
    input  wire                can_alloc2,

    // Reorder buffer status
    input  wire                rob_room2,
    input  wire                busy,

    // Map table lookups
    input  wire [preg_w-1:0]   map_prs0,
    input  wire [preg_w-1:0]   map_prs1,
    input  wire [preg_w-1:0]   map_old0,
    input  wire [preg_w-1:0]   map_old1,

    // Routed slot fields for the map table and the ROB
    output logic [areg_w-1:0]  rd0,
    output logic [areg_w-1:0]  rd1,
    output logic [areg_w-1:0]  rs0,
    output logic [areg_w-1:0]  rs1,
    output logic [preg_w-1:0]  prd0,
    output logic [preg_w-1:0]  prd1,

    // Slot enables
    output logic               wr0,
    output logic               wr1,
    output logic               enq0,
    output logic               enq1,

    // Renamed pair, one cycle after accept
    output logic               out0_valid,
    output logic [preg_w-1:0]  out0_prd,
    output logic [preg_w-1:0]  out0_prs,
    output logic [preg_w-1:0]  out0_old,
    output logic               out1_valid,
    output logic [preg_w-1:0]  out1_prd,
    output logic [preg_w-1:0]  out1_prs,
    output logic [preg_w-1:0]  out1_old
);

    logic take0;  // Slot 0 accepted this edge
    logic take1;

    // Room for a full pair on every side, never during a walk
    assign in_ready = !busy && can_alloc2 && rob_room2;

    assign take0 = in_ready && in0_valid;
    assign take1 = take0 && in1_valid;  // Slot 1 never goes alone

    // Same enables to all three consumers
    assign alloc0 = take0;
    assign alloc1 = take1;
    assign wr0    = take0;
    assign wr1    = take1;
    assign enq0   = take0;
    assign enq1   = take1;

    // Fields to the map table and the ROB
    assign rd0  = in0_rd;
    assign rd1  = in1_rd;
    assign rs0  = in0_rs;
    assign rs1  = in1_rs;
    assign prd0 = alloc_preg0;  // Head of free list
    assign prd1 = alloc_preg1;

    // Output valids
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            out0_valid <= 1'b0;
            out1_valid <= 1'b0;
        end else begin
            out0_valid <= take0;
            out1_valid <= take1;
        end
    end

    // Payload captured only on accept
    always_ff @(posedge clock) begin
        if (take0) begin
            out0_prd <= alloc_preg0;
            out0_prs <= map_prs0;
            out0_old <= map_old0;
        end
        if (take1) begin
            out1_prd <= alloc_preg1;
            out1_prs <= map_prs1;  // Bypassed inside the table
            out1_old <= map_old1;
        end
    end

endmodule

`default_nettype wire

/* reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import rename_pkg::*; (
    input  wire                clock,
    input  wire                reset_n,

    // Enqueue from rename
    input  wire                enq0,
    input  wire                enq1,
    input  wire [areg_w-1:0]   rd0,
    input  wire [areg_w-1:0]   rd1,
    input  wire [preg_w-1:0]   prd0,
    input  wire [preg_w-1:0]   prd1,
    input  wire [preg_w-1:0]   old0,
    input  wire [preg_w-1:0]   old1,

    // Retirement and flush
    input  wire                retire0,
    input  wire                retire1,
    input  wire                flush,

    // Released registers to the free list
    output logic               free0_valid,
    output logic               free1_valid,
    output logic [preg_w-1:0]  free0_preg,
    output logic [preg_w-1:0]  free1_preg,

    // Walk, walk0 is the youngest entry
    output rob_state_e         rob_state,
    output logic               walk0_valid,
    output logic               walk1_valid,
    output logic [areg_w-1:0]  walk0_rd,
    output logic [areg_w-1:0]  walk1_rd,
    output logic [preg_w-1:0]  walk0_old,
    output logic [preg_w-1:0]  walk1_old,

    output logic               rob_room2,  // Two or more empty entries
    output logic               busy
);

    logic [rob_entry_w-1:0] entry_q [rob_depth];  // {rd, prd, old}

    logic [rob_ptr_w:0]     head_q;   // Oldest entry
    logic [rob_ptr_w:0]     tail_q;   // Next free entry
    logic [rob_ptr_w:0]     used;
    rob_state_e             state_q;

    logic [rob_ptr_w-1:0]   head_idx0;
    logic [rob_ptr_w-1:0]   head_idx1;
    logic [rob_ptr_w-1:0]   tail_idx0;
    logic [rob_ptr_w-1:0]   tail_idx1;
    logic [rob_ptr_w-1:0]   walk_idx0;
    logic [rob_ptr_w-1:0]   walk_idx1;

    logic [rob_entry_w-1:0] head_e0;
    logic [rob_entry_w-1:0] head_e1;
    logic [rob_entry_w-1:0] walk_e0;
    logic [rob_entry_w-1:0] walk_e1;

    logic [1:0]             enq_cnt;
    logic [1:0]             ret_req;
    logic [1:0]             ret_cnt;
    logic [1:0]             walk_cnt;

    assign head_idx0 = head_q[rob_ptr_w-1:0];
    assign head_idx1 = head_idx0 + 1'b1;
    assign tail_idx0 = tail_q[rob_ptr_w-1:0];
    assign tail_idx1 = tail_idx0 + 1'b1;
    assign walk_idx0 = tail_idx0 - 1'b1;  // Youngest
    assign walk_idx1 = tail_idx0 - 2'd2;  // Next older

    assign used      = tail_q - head_q;
    assign rob_room2 = used <= (rob_depth - 2);

    assign rob_state = state_q;
    assign busy      = state_q == rob_walk;

    assign enq_cnt = {1'b0, enq0} + {1'b0, enq1};
    assign ret_req = {1'b0, retire0} + {1'b0, retire1};

    // Retire only what is there, and nothing once a walk is running
    always_comb begin
        if (state_q != rob_idle) begin
            ret_cnt = 2'd0;
        end else if (used < ret_req) begin
            ret_cnt = used[1:0];  // 0 or 1 here
        end else begin
            ret_cnt = ret_req;
        end
    end

    // Up to two restores per walk cycle
    always_comb begin
        if (state_q != rob_walk) begin
            walk_cnt = 2'd0;
        end else if (used >= 2) begin
            walk_cnt = 2'd2;
        end else begin
            walk_cnt = used[1:0];
        end
    end

    assign head_e0 = entry_q[head_idx0];
    assign head_e1 = entry_q[head_idx1];
    assign walk_e0 = entry_q[walk_idx0];
    assign walk_e1 = entry_q[walk_idx1];

    // Old register goes back to the free list on the retire edge
    assign free0_valid = ret_cnt != 2'd0;
    assign free1_valid = ret_cnt == 2'd2;
    assign free0_preg  = head_e0[preg_w-1:0];
    assign free1_preg  = head_e1[preg_w-1:0];

    assign walk0_valid = walk_cnt != 2'd0;
    assign walk1_valid = walk_cnt == 2'd2;
    assign walk0_rd    = walk_e0[rob_entry_w-1 -: areg_w];
    assign walk1_rd    = walk_e1[rob_entry_w-1 -: areg_w];
    assign walk0_old   = walk_e0[preg_w-1:0];
    assign walk1_old   = walk_e1[preg_w-1:0];

    // Pointers and recovery FSM
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            state_q <= rob_idle;
        end else if (state_q == rob_walk) begin
            tail_q <= tail_q - walk_cnt;  // Pop from the young end
            if (used <= 2) begin
                state_q <= rob_idle;  // Tail meets head after this pop
            end
        end else begin
            head_q <= head_q + ret_cnt;
            tail_q <= tail_q + enq_cnt;
            if (flush) begin
                state_q <= rob_walk;  // Everything past head is discarded
            end
        end
    end

    // Entry storage
    always_ff @(posedge clock) begin
        if (enq0) begin
            entry_q[tail_idx0] <= {rd0, prd0, old0};
        end
        if (enq1) begin
            entry_q[tail_idx1] <= {rd1, prd1, old1};
        end
    end

endmodule

`default_nettype wire

/* rename_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_core_top import rename_pkg::*; (
    input  wire                clock,
    input  wire                reset_n,

    input  wire                in0_valid,
    input  wire [areg_w-1:0]   in0_rd,
    input  wire [areg_w-1:0]   in0_rs,
    input  wire                in1_valid,
    input  wire [areg_w-1:0]   in1_rd,
    input  wire [areg_w-1:0]   in1_rs,
    output logic               in_ready,

    input  wire                retire0,
    input  wire                retire1,
    input  wire                flush,
    output logic               busy,

    output logic               out0_valid,
    output logic [preg_w-1:0]  out0_prd,
    output logic [preg_w-1:0]  out0_prs,
    output logic [preg_w-1:0]  out0_old,
    output logic               out1_valid,
    output logic [preg_w-1:0]  out1_prd,
    output logic [preg_w-1:0]  out1_prs,
    output logic [preg_w-1:0]  out1_old
);

    // Rename to free list
    logic              alloc0, alloc1, can_alloc2;
    logic [preg_w-1:0] alloc_preg0, alloc_preg1;

    // Rename to map table and ROB
    logic              wr0, wr1, enq0, enq1;
    logic [areg_w-1:0] rd0, rd1, rs0, rs1;
    logic [preg_w-1:0] prd0, prd1;
    logic [preg_w-1:0] map_prs0, map_prs1, map_old0, map_old1;

    // ROB to the rest
    logic              rob_room2;
    logic              free0_valid, free1_valid;
    logic [preg_w-1:0] free0_preg, free1_preg;
    rob_state_e        rob_state;
    logic              walk0_valid, walk1_valid;
    logic [areg_w-1:0] walk0_rd, walk1_rd;
    logic [preg_w-1:0] walk0_old, walk1_old;

    rename_stage rename_stage_i (
        .clock, .reset_n,
        .in0_valid, .in0_rd, .in0_rs, .in1_valid, .in1_rd, .in1_rs, .in_ready,
        .alloc0, .alloc1, .alloc_preg0, .alloc_preg1, .can_alloc2,
        .rob_room2, .busy,
        .map_prs0, .map_prs1, .map_old0, .map_old1,
        .rd0, .rd1, .rs0, .rs1, .prd0, .prd1,
        .wr0, .wr1, .enq0, .enq1,
        .out0_valid, .out0_prd, .out0_prs, .out0_old,
        .out1_valid, .out1_prd, .out1_prs, .out1_old
    );

    free_list free_list_i (
        .clock, .reset_n,
        .alloc0, .alloc1, .alloc_preg0, .alloc_preg1,
        .free0_valid, .free1_valid, .free0_preg, .free1_preg,
        .rob_state, .walk0_valid, .walk1_valid,
        .can_alloc2
    );

    rename_map_table rename_map_table_i (
        .clock, .reset_n,
        .wr0, .wr1, .rd0, .rd1, .rs0, .rs1, .prd0, .prd1,
        .map_prs0, .map_prs1, .map_old0, .map_old1,
        .rob_state, .walk0_valid, .walk1_valid,
        .walk0_rd, .walk1_rd, .walk0_old, .walk1_old
    );

    // Old mappings go straight from the table into the ROB entry
    reorder_buffer reorder_buffer_i (
        .clock, .reset_n,
        .enq0, .enq1, .rd0, .rd1, .prd0, .prd1,
        .old0 (map_old0),
        .old1 (map_old1),
        .retire0, .retire1, .flush,
        .free0_valid, .free1_valid, .free0_preg, .free1_preg,
        .rob_state, .walk0_valid, .walk1_valid,
        .walk0_rd, .walk1_rd, .walk0_old, .walk1_old,
        .rob_room2, .busy
    );

endmodule

`default_nettype wire

/* rename_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb import rename_pkg::*; ();

    localparam int n_basic  = 4;
    localparam int n_bypass = 5;
    localparam int n_random = 60;
    localparam int n_flush  = 9;    // Groups issued around the two flushes
    localparam int n_full   = 10;
    localparam int max_wait = 64;   // Cycles a held group or a walk may take
    // Reset, about three cycles per group, plus walks and idle gaps
    localparam int test_cycles = 3 + 3 * (n_basic + n_bypass + n_random + n_flush + n_full)
                                 + 200;

    logic              clock;
    logic              reset_n;
    logic              in0_valid, in1_valid;
    logic [areg_w-1:0] in0_rd, in0_rs, in1_rd, in1_rs;
    logic              in_ready;
    logic              retire0, retire1, flush, busy;
    logic              out0_valid, out1_valid;
    logic [preg_w-1:0] out0_prd, out0_prs, out0_old;
    logic [preg_w-1:0] out1_prd, out1_prs, out1_old;

    // Reference model state
    logic [preg_w-1:0] model_map [arch_regs];
    logic [preg_w-1:0] free_q [$];        // Front is the next register handed out
    logic [areg_w-1:0] rob_rd [$];        // Oldest entry at the front
    logic [preg_w-1:0] rob_prd [$];
    logic [preg_w-1:0] rob_old [$];
    int                walk_left;         // Walk cycles still to come

    // Expected responses, valid at the edge after they are set
    logic              exp0_valid, exp1_valid, exp_ready, exp_busy;
    logic [preg_w-1:0] exp0_prd, exp0_prs, exp0_old;
    logic [preg_w-1:0] exp1_prd, exp1_prs, exp1_old;

    int                error_count;
    int                test_start_errors;
    int                tests_run;
    int                tests_failed;
    int                seed;
    logic [31:0]       rnd;

    rename_core_top rename_core_top_i (.*);

    always #50 clock = ~clock;  // 100 ns period

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] want);
        error_count++;
        $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, want, $time);
    endtask

    ready_check: assert property (@(posedge clock) disable iff (!reset_n)
        in_ready == exp_ready)
        else report_mismatch("in_ready", $sampled(in_ready), $sampled(exp_ready));
    busy_check: assert property (@(posedge clock) disable iff (!reset_n)
        busy == exp_busy)
        else report_mismatch("busy", $sampled(busy), $sampled(exp_busy));
    out0_valid_check: assert property (@(posedge clock) disable iff (!reset_n)
        out0_valid == exp0_valid)
        else report_mismatch("out0_valid", $sampled(out0_valid), $sampled(exp0_valid));
    out1_valid_check: assert property (@(posedge clock) disable iff (!reset_n)
        out1_valid == exp1_valid)
        else report_mismatch("out1_valid", $sampled(out1_valid), $sampled(exp1_valid));
    out0_prd_check: assert property (@(posedge clock) disable iff (!reset_n)
        exp0_valid |-> out0_prd == exp0_prd)
        else report_mismatch("out0_prd", $sampled(out0_prd), $sampled(exp0_prd));
    out0_prs_check: assert property (@(posedge clock) disable iff (!reset_n)
        exp0_valid |-> out0_prs == exp0_prs)
        else report_mismatch("out0_prs", $sampled(out0_prs), $sampled(exp0_prs));
    out0_old_check: assert property (@(posedge clock) disable iff (!reset_n)
        exp0_valid |-> out0_old == exp0_old)
        else report_mismatch("out0_old", $sampled(out0_old), $sampled(exp0_old));
    out1_prd_check: assert property (@(posedge clock) disable iff (!reset_n)
        exp1_valid |-> out1_prd == exp1_prd)
        else report_mismatch("out1_prd", $sampled(out1_prd), $sampled(exp1_prd));
    out1_prs_check: assert property (@(posedge clock) disable iff (!reset_n)
        exp1_valid |-> out1_prs == exp1_prs)
        else report_mismatch("out1_prs", $sampled(out1_prs), $sampled(exp1_prs));
    out1_old_check: assert property (@(posedge clock) disable iff (!reset_n)
        exp1_valid |-> out1_old == exp1_old)
        else report_mismatch("out1_old", $sampled(out1_old), $sampled(exp1_old));

    task automatic model_reset();
        free_q.delete();
        rob_rd.delete();
        rob_prd.delete();
        rob_old.delete();
        for (int i = 0; i < arch_regs; i++) begin
            model_map[i] = preg_w'(i);  // Identity map
        end
        for (int i = 0; i < freelist_size; i++) begin
            free_q.push_back(preg_w'(arch_regs + i));
        end
        walk_left  = 0;
        exp0_valid = 1'b0;
        exp1_valid = 1'b0;
        exp_busy   = 1'b0;
        exp_ready  = 1'b1;
    endtask

    // One slot in program order, source read before the destination is remapped
    task automatic rename_slot(input logic [areg_w-1:0] rd, input logic [areg_w-1:0] rs,
                               output logic [preg_w-1:0] prd, output logic [preg_w-1:0] prs,
                               output logic [preg_w-1:0] old);
        prd = free_q.pop_front();
        prs = model_map[rs];
        old = model_map[rd];
        model_map[rd] = prd;
        rob_rd.push_back(rd);
        rob_prd.push_back(prd);
        rob_old.push_back(old);
    endtask

    task automatic model_step();
        bit                ready;
        int                n_ret;
        logic [areg_w-1:0] rd_w;
        logic [preg_w-1:0] prd_w;
        logic [preg_w-1:0] old_w;
        ready = (walk_left == 0) && (free_q.size() >= 2) && (rob_rd.size() <= rob_depth - 2);
        exp0_valid = 1'b0;
        exp1_valid = 1'b0;
        if (walk_left > 0) begin
            walk_left--;  // Nothing retires or renames during a walk
        end else begin
            n_ret = int'(retire0) + int'(retire1);
            for (int k = 0; k < n_ret; k++) begin
                if (rob_rd.size() > 0) begin
                    void'(rob_rd.pop_front());
                    void'(rob_prd.pop_front());
                    free_q.push_back(rob_old.pop_front());  // Old register is free again
                end
            end
            if (ready && in0_valid) begin
                rename_slot(in0_rd, in0_rs, exp0_prd, exp0_prs, exp0_old);
                exp0_valid = 1'b1;
                if (in1_valid) begin
                    rename_slot(in1_rd, in1_rs, exp1_prd, exp1_prs, exp1_old);
                    exp1_valid = 1'b1;
                end
            end
            if (flush) begin
                // Two entries per walk cycle, at least one cycle
                walk_left = (rob_rd.size() + 1) / 2;
                if (walk_left == 0) begin
                    walk_left = 1;
                end
                while (rob_rd.size() > 0) begin
                    rd_w  = rob_rd.pop_back();
                    prd_w = rob_prd.pop_back();
                    old_w = rob_old.pop_back();
                    model_map[rd_w] = old_w;
                    free_q.push_front(prd_w);  // Youngest first, so oldest ends at front
                end
            end
        end
        exp_busy  = walk_left > 0;
        exp_ready = (walk_left == 0) && (free_q.size() >= 2)
                    && (rob_rd.size() <= rob_depth - 2);
    endtask

    always @(posedge clock) begin
        if (!reset_n) begin
            model_reset();
        end else begin
            model_step();
        end
    end

    // Group held until accepted, retires held with it
    task automatic send_group(input bit two, input logic [areg_w-1:0] rd0,
                              input logic [areg_w-1:0] rs0, input logic [areg_w-1:0] rd1,
                              input logic [areg_w-1:0] rs1, input bit r0, input bit r1);
        int waited;
        bit taken;
        waited = 0;
        taken  = 1'b0;
        in0_valid <= 1'b1;
        in0_rd    <= rd0;
        in0_rs    <= rs0;
        in1_valid <= two;
        in1_rd    <= rd1;
        in1_rs    <= rs1;
        retire0   <= r0;
        retire1   <= r1;
        while (!taken && waited < max_wait) begin
            @(negedge clock);
            taken = in_ready;  // Stable here, decides the next edge
            @(posedge clock);
            waited++;
        end
        in0_valid <= 1'b0;
        in1_valid <= 1'b0;
        retire0   <= 1'b0;
        retire1   <= 1'b0;
        if (!taken) begin
            error_count++;
            $display("Group with rd0 %0d not accepted within %0d cycles", rd0, max_wait);
        end
    endtask

    task automatic retire_cycles(input int n);
        retire0 <= 1'b1;
        retire1 <= 1'b1;
        repeat (n) @(posedge clock);
        retire0 <= 1'b0;
        retire1 <= 1'b0;
    endtask

    task automatic start_flush();
        flush <= 1'b1;
        @(posedge clock);
        flush <= 1'b0;
    endtask

    task automatic wait_walk_done();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (busy && cycles < max_wait) begin
            @(negedge clock);
            cycles++;
        end
        if (busy) begin
            error_count++;
            $display("Walk still running after %0d cycles", max_wait);
        end
        @(posedge clock);
    endtask

    task automatic finish_test(input string name);
        repeat (2) @(posedge clock);  // Let the last output checks fire
        tests_run++;
        if (error_count == test_start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    initial begin
        #(test_cycles * 100 * 2);
        $display("Watchdog expired after %0d cycles, run did not finish", test_cycles * 2);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        seed              = 15;
        error_count       = 0;
        test_start_errors = 0;
        tests_run         = 0;
        tests_failed      = 0;
        clock     = 1'b0;
        reset_n   = 1'b0;
        in0_valid = 1'b0;
        in0_rd    = '0;
        in0_rs    = '0;
        in1_valid = 1'b0;
        in1_rd    = '0;
        in1_rs    = '0;
        retire0   = 1'b0;
        retire1   = 1'b0;
        flush     = 1'b0;
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;

        // First allocations straight from the reset free list
        send_group(1'b1, 5'd1, 5'd0, 5'd2, 5'd3, 1'b0, 1'b0);
        send_group(1'b1, 5'd3, 5'd1, 5'd4, 5'd2, 1'b0, 1'b0);
        send_group(1'b0, 5'd10, 5'd4, 5'd0, 5'd0, 1'b0, 1'b0);
        send_group(1'b1, 5'd11, 5'd3, 5'd12, 5'd10, 1'b0, 1'b0);
        finish_test("reset_allocation");

        send_group(1'b1, 5'd5, 5'd5, 5'd6, 5'd5, 1'b1, 1'b1);   // Slot 1 reads slot 0
        send_group(1'b1, 5'd7, 5'd1, 5'd7, 5'd7, 1'b1, 1'b1);   // Same rd in both slots
        send_group(1'b1, 5'd9, 5'd9, 5'd9, 5'd3, 1'b1, 1'b1);
        send_group(1'b1, 5'd8, 5'd7, 5'd8, 5'd8, 1'b1, 1'b1);
        send_group(1'b0, 5'd9, 5'd9, 5'd0, 5'd0, 1'b1, 1'b1);
        finish_test("group_bypass");

        // Enough groups to wrap the free list several times
        for (int i = 0; i < n_random; i++) begin
            rnd = $random(seed);
            send_group(rnd[0], rnd[5:1], rnd[10:6], rnd[15:11], rnd[20:16], 1'b1, rnd[21]);
        end
        finish_test("retire_reuse");

        for (int i = 0; i < 5; i++) begin
            send_group(1'b1, areg_w'(16 + i), areg_w'(i), areg_w'(24 + i), areg_w'(16 + i),
                       1'b1, 1'b0);
        end
        start_flush();
        wait_walk_done();
        send_group(1'b1, 5'd30, 5'd16, 5'd31, 5'd24, 1'b0, 1'b0);
        send_group(1'b1, 5'd16, 5'd20, 5'd24, 5'd28, 1'b0, 1'b0);
        send_group(1'b0, 5'd17, 5'd30, 5'd0, 5'd0, 1'b0, 1'b0);
        retire_cycles(10);
        start_flush();  // Empty ROB, walk of one cycle
        wait_walk_done();
        send_group(1'b1, 5'd18, 5'd17, 5'd19, 5'd18, 1'b0, 1'b0);
        finish_test("flush_recovery");

        retire_cycles(10);
        for (int i = 0; i < 8; i++) begin
            send_group(1'b1, areg_w'(i), areg_w'(i + 8), areg_w'(i + 16), areg_w'(i),
                       1'b0, 1'b0);
        end
        // ROB full, group sits on the inputs without retires
        in0_valid <= 1'b1;
        in0_rd    <= 5'd3;
        in0_rs    <= 5'd3;
        in1_valid <= 1'b1;
        in1_rd    <= 5'd4;
        in1_rs    <= 5'd3;
        repeat (4) @(posedge clock);
        send_group(1'b1, 5'd3, 5'd3, 5'd4, 5'd3, 1'b1, 1'b1);
        start_flush();
        send_group(1'b1, 5'd2, 5'd4, 5'd5, 5'd2, 1'b0, 1'b0);   // Held through the walk
        finish_test("backpressure");

        $display("%0d tests, %0d with errors, %0d errors in total",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
rename_pkg.sv
free_list.sv
rename_map_table.sv
rename_stage.sv
reorder_buffer.sv
rename_core_top.sv
rename_core_tb.sv

/* Bender.yml */
package:
  name: rename_core

sources:
  - rename_pkg.sv
  - free_list.sv
  - rename_map_table.sv
  - rename_stage.sv
  - reorder_buffer.sv
  - rename_core_top.sv
  - target: test
    files:
      - rename_core_tb.sv
